/* logic/elem_pkg.sv */
/* Element unit package
   Widths, meaningful vector types, enums and the structs passed between stages */

`default_nettype none

package elem_pkg;

        localparam int unsigned ID_W       = 3;
        localparam int unsigned ID_CNT     = 8;
        localparam int unsigned ELEM_W     = 32;
        localparam int unsigned VD_COUNT_W = 5;   // [1:0] byte in word, [4:2] register in group

        typedef logic [ID_W-1:0]   instr_id_t;
        typedef logic [ID_CNT-1:0] id_flags_t;
        typedef logic [4:0]        vreg_addr_t;
        typedef logic [4:0]        xreg_addr_t;
        typedef logic [ELEM_W-1:0] word_t;
        typedef logic [3:0]        byte_mask_t;

        typedef enum logic [1:0] {
                VSEW_8  = 2'd0,
                VSEW_16 = 2'd1,
                VSEW_32 = 2'd2
        } vsew_t;

        // Code doubles as the pending-clear count
        typedef enum logic [1:0] {
                EMUL_1 = 2'd0,
                EMUL_2 = 2'd1,
                EMUL_4 = 2'd2,
                EMUL_8 = 2'd3
        } emul_t;

        typedef enum logic [1:0] {
                ELEM_MOVE     = 2'd0,
                ELEM_COMPRESS = 2'd1,
                ELEM_XMV      = 2'd2   // Extract first element to scalar
        } elem_op_t;

        typedef struct packed {
                instr_id_t  id;
                elem_op_t   op;
                vsew_t      eew;
                emul_t      emul;
                vreg_addr_t res_vaddr;   // Base register of the group
                xreg_addr_t xreg_addr;
                logic       first_cycle;
                logic       last_cycle;
        } elem_ctrl_t;

        typedef struct packed {
                elem_ctrl_t ctrl;
                word_t      elem;
                logic       res_valid;
        } elem_beat_t;

        typedef struct packed {
                vreg_addr_t vaddr;
                word_t      data;
                byte_mask_t mask;
        } vreg_wr_t;

endpackage

`default_nettype wire

/* logic/elem_op_stage.sv */
/* Element operation stage
   Registers each beat, trims the element to its width and flags valid results */

`timescale 1ns/1ps
`default_nettype none

module elem_op_stage (
        input  wire logic                clk_i,
        input  wire logic                reset_i,

        input  wire logic                in_valid_i,
        output logic                     in_ready_o,
        input  wire elem_pkg::elem_ctrl_t in_ctrl_i,
        input  wire elem_pkg::word_t     in_elem_i,
        input  wire logic                in_mask_i,

        output logic                     out_valid_o,
        input  wire logic                out_ready_i,
        output elem_pkg::elem_beat_t     out_beat_o
);

        logic                 valid_q;
        elem_pkg::elem_beat_t beat_q;
        elem_pkg::elem_beat_t beat_d;

        assign in_ready_o = out_ready_i | ~valid_q;

        always_comb begin
                beat_d      = '0;
                beat_d.ctrl = in_ctrl_i;

                // Zero everything above the element width
                case (in_ctrl_i.eew)
                        elem_pkg::VSEW_8:  beat_d.elem = {24'b0, in_elem_i[7:0]};
                        elem_pkg::VSEW_16: beat_d.elem = {16'b0, in_elem_i[15:0]};
                        default:           beat_d.elem = in_elem_i;
                endcase

                case (in_ctrl_i.op)
                        elem_pkg::ELEM_MOVE:     beat_d.res_valid = 1'b1;
                        elem_pkg::ELEM_COMPRESS: beat_d.res_valid = in_mask_i;
                        elem_pkg::ELEM_XMV:      beat_d.res_valid = in_ctrl_i.first_cycle;
                        default:                 beat_d.res_valid = 1'b0;
                endcase
        end

        always_ff @(posedge clk_i) begin
                if (reset_i) begin
                        valid_q <= 1'b0;
                end else if (in_ready_o) begin
                        valid_q <= in_valid_i;
                end
        end

        always_ff @(posedge clk_i) begin
                if (in_valid_i && in_ready_o) begin
                        beat_q <= beat_d;
                end
        end

        assign out_valid_o = valid_q;
        assign out_beat_o  = beat_q;

        // A stalled beat must be held unchanged until the packer takes it
        assert property (@(posedge clk_i) disable iff (reset_i)
                out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_beat_o.ctrl))
                else $error("op stage output changed while stalled");

endmodule

`default_nettype wire

/* logic/elem_vd_packer.sv */
/* Destination packer
   Counts result bytes per instruction, packs them into words and forms the vreg address */

`timescale 1ns/1ps
`default_nettype none

module elem_vd_packer (
        input  wire logic                 clk_i,
        input  wire logic                 reset_i,

        input  wire logic                 in_valid_i,
        output logic                      in_ready_o,
        input  wire elem_pkg::elem_beat_t in_beat_i,

        output logic                      out_valid_o,
        input  wire logic                 out_ready_i,
        output elem_pkg::elem_beat_t      out_beat_o,
        output logic                      out_store_o,
        output elem_pkg::vreg_wr_t        out_wr_o
);

        logic [elem_pkg::VD_COUNT_W-1:0] count_q, count_d, base;
        logic [elem_pkg::VD_COUNT_W-1:0] nbytes;
        logic [elem_pkg::VD_COUNT_W:0]   count_sum;   // One extra bit so a full group is visible
        logic                            has_valid_q, has_valid_d;
        elem_pkg::word_t                 acc_word_q, acc_word_d;
        elem_pkg::byte_mask_t            acc_mask_q, acc_mask_d;
        elem_pkg::byte_mask_t            elem_mask;
        logic [1:0]                      pos;
        logic [2:0]                      ridx;
        logic                            cnt_en, first_valid, in_fire;
        logic                            valid_q, store_d, store_q;
        elem_pkg::elem_beat_t            beat_q;
        elem_pkg::vreg_wr_t              wr_d, wr_q;

        assign in_ready_o = out_ready_i | ~valid_q;
        assign in_fire    = in_valid_i & in_ready_o;

        // Scalar extracts never touch the destination register
        assign cnt_en      = in_beat_i.res_valid & (in_beat_i.ctrl.op != elem_pkg::ELEM_XMV);
        assign first_valid = cnt_en & (in_beat_i.ctrl.first_cycle | ~has_valid_q);
        assign base        = first_valid ? '0 : count_q;
        assign pos         = base[1:0];
        assign count_sum   = {1'b0, base} + {1'b0, nbytes};

        always_comb begin
                case (in_beat_i.ctrl.eew)
                        elem_pkg::VSEW_8:  nbytes = 5'd1;
                        elem_pkg::VSEW_16: nbytes = 5'd2;
                        default:           nbytes = 5'd4;
                endcase
        end

        assign elem_mask = elem_pkg::byte_mask_t'((5'd1 << nbytes) - 5'd1);

        always_comb begin
                count_d     = count_q;
                has_valid_d = has_valid_q & ~in_beat_i.ctrl.first_cycle;
                acc_word_d  = acc_word_q;
                acc_mask_d  = in_beat_i.ctrl.first_cycle ? '0 : acc_mask_q;
                store_d     = 1'b0;
                ridx        = count_q[4:2];
                if (cnt_en) begin
                        count_d     = count_sum[elem_pkg::VD_COUNT_W-1:0];
                        has_valid_d = 1'b1;
                        ridx        = base[4:2];
                        // A word starting at byte 0 drops the previous contents
                        acc_word_d  = (pos == 2'd0 ? '0 : acc_word_q) |
                                      elem_pkg::word_t'(in_beat_i.elem << {pos, 3'b000});
                        acc_mask_d  = (pos == 2'd0 ? '0 : acc_mask_q) |
                                      elem_pkg::byte_mask_t'(elem_mask << pos);
                        store_d     = (count_sum[1:0] == 2'd0) | in_beat_i.ctrl.last_cycle;
                end else if (in_beat_i.ctrl.op != elem_pkg::ELEM_XMV) begin
                        store_d = in_beat_i.ctrl.last_cycle & (acc_mask_d != '0);
                end
        end

        always_comb begin
                wr_d.data = acc_word_d;
                wr_d.mask = acc_mask_d;
                case (in_beat_i.ctrl.emul)
                        elem_pkg::EMUL_2: wr_d.vaddr = in_beat_i.ctrl.res_vaddr | {4'b0, ridx[0]};
                        elem_pkg::EMUL_4: wr_d.vaddr = in_beat_i.ctrl.res_vaddr | {3'b0, ridx[1:0]};
                        elem_pkg::EMUL_8: wr_d.vaddr = in_beat_i.ctrl.res_vaddr | {2'b0, ridx};
                        default:          wr_d.vaddr = in_beat_i.ctrl.res_vaddr;
                endcase
        end

        always_ff @(posedge clk_i) begin
                if (reset_i) begin
                        valid_q     <= 1'b0;
                        count_q     <= '0;
                        has_valid_q <= 1'b0;
                        acc_mask_q  <= '0;
                end else begin
                        if (in_ready_o) begin
                                valid_q <= in_valid_i;
                        end
                        if (in_fire) begin
                                count_q     <= count_d;
                                has_valid_q <= has_valid_d;
                                acc_mask_q  <= store_d ? '0 : acc_mask_d;   // Stored bytes are done
                        end
                end
        end

        always_ff @(posedge clk_i) begin
                if (in_fire) begin
                        acc_word_q <= acc_word_d;
                        beat_q     <= in_beat_i;
                        store_q    <= store_d;
                        wr_q       <= wr_d;
                end
        end

        assign out_valid_o = valid_q;
        assign out_beat_o  = beat_q;
        assign out_store_o = store_q;
        assign out_wr_o    = wr_q;

        // Results of one instruction must fit in its destination register group
        assert property (@(posedge clk_i) disable iff (reset_i)
                in_fire && cnt_en |-> count_sum <= (6'd4 << in_beat_i.ctrl.emul))
                else $error("byte counter ran past the register group");

endmodule

`default_nettype wire

/* logic/elem_writeback.sv */
/* Element writeback
   Issues vreg writes and scalar results, holds speculative scalars, drops killed ones */

`timescale 1ns/1ps
`default_nettype none

module elem_writeback (
        input  wire logic                 in_valid_i,
        output logic                      in_ready_o,
        input  wire elem_pkg::elem_beat_t in_beat_i,
        input  wire logic                 in_store_i,
        input  wire elem_pkg::vreg_wr_t   in_wr_i,

        output logic                      vreg_wr_valid_o,
        input  wire logic                 vreg_wr_ready_i,
        output elem_pkg::vreg_wr_t        vreg_wr_o,

        output logic                      xreg_valid_o,
        output elem_pkg::instr_id_t       xreg_id_o,
        output elem_pkg::xreg_addr_t      xreg_addr_o,
        output elem_pkg::word_t           xreg_data_o,

        input  wire elem_pkg::id_flags_t  instr_spec_i,
        input  wire elem_pkg::id_flags_t  instr_killed_i,

        output logic                      pend_clear_o,
        output elem_pkg::emul_t           pend_clear_cnt_o,
        output logic                      instr_done_o
);

        logic xreg_beat;
        logic stall;
        logic is_xmv;
        logic fire;

        assign is_xmv    = in_beat_i.ctrl.op == elem_pkg::ELEM_XMV;
        assign xreg_beat = is_xmv & in_beat_i.res_valid;
        assign stall     = xreg_beat & instr_spec_i[in_beat_i.ctrl.id];   // Wait until resolved

        // Beats without a write due do not wait on the vreg port
        assign in_ready_o = ~stall & (~in_store_i | vreg_wr_ready_i);
        assign fire       = in_valid_i & in_ready_o;

        assign vreg_wr_valid_o = in_valid_i & in_store_i;
        assign vreg_wr_o       = in_wr_i;

        assign xreg_valid_o = fire & xreg_beat & ~instr_killed_i[in_beat_i.ctrl.id];
        assign xreg_id_o    = in_beat_i.ctrl.id;
        assign xreg_addr_o  = in_beat_i.ctrl.xreg_addr;
        assign xreg_data_o  = in_beat_i.elem;

        assign instr_done_o     = fire & in_beat_i.ctrl.last_cycle;
        assign pend_clear_o     = fire & in_beat_i.ctrl.last_cycle & ~is_xmv;
        assign pend_clear_cnt_o = in_beat_i.ctrl.emul;

endmodule

`default_nettype wire

/* logic/elem_unit_top.sv */
/* Element unit top
   Op stage, destination packer and writeback in a chain */

`timescale 1ns/1ps
`default_nettype none

module elem_unit_top (
        input  wire logic                 clk_i,
        input  wire logic                 reset_i,

        input  wire logic                 in_valid_i,
        output logic                      in_ready_o,
        input  wire elem_pkg::elem_ctrl_t in_ctrl_i,
        input  wire elem_pkg::word_t      in_elem_i,
        input  wire logic                 in_mask_i,

        output logic                      vreg_wr_valid_o,
        input  wire logic                 vreg_wr_ready_i,
        output elem_pkg::vreg_wr_t        vreg_wr_o,

        output logic                      xreg_valid_o,
        output elem_pkg::instr_id_t       xreg_id_o,
        output elem_pkg::xreg_addr_t      xreg_addr_o,
        output elem_pkg::word_t           xreg_data_o,

        input  wire elem_pkg::id_flags_t  instr_spec_i,
        input  wire elem_pkg::id_flags_t  instr_killed_i,

        output logic                      pend_clear_o,
        output elem_pkg::emul_t           pend_clear_cnt_o,
        output logic                      instr_done_o
);

        logic                 op_valid, op_ready;
        elem_pkg::elem_beat_t op_beat;
        logic                 pk_valid, pk_ready, pk_store;
        elem_pkg::elem_beat_t pk_beat;
        elem_pkg::vreg_wr_t   pk_wr;

        elem_op_stage op_stage (
                .clk_i       ( clk_i      ),
                .reset_i     ( reset_i    ),
                .in_valid_i  ( in_valid_i ),
                .in_ready_o  ( in_ready_o ),
                .in_ctrl_i   ( in_ctrl_i  ),
                .in_elem_i   ( in_elem_i  ),
                .in_mask_i   ( in_mask_i  ),
                .out_valid_o ( op_valid   ),
                .out_ready_i ( op_ready   ),
                .out_beat_o  ( op_beat    )
        );

        elem_vd_packer packer (
                .clk_i       ( clk_i    ),
                .reset_i     ( reset_i  ),
                .in_valid_i  ( op_valid ),
                .in_ready_o  ( op_ready ),
                .in_beat_i   ( op_beat  ),
                .out_valid_o ( pk_valid ),
                .out_ready_i ( pk_ready ),
                .out_beat_o  ( pk_beat  ),
                .out_store_o ( pk_store ),
                .out_wr_o    ( pk_wr    )
        );

        elem_writeback writeback (
                .in_valid_i       ( pk_valid         ),
                .in_ready_o       ( pk_ready         ),
                .in_beat_i        ( pk_beat          ),
                .in_store_i       ( pk_store         ),
                .in_wr_i          ( pk_wr            ),
                .vreg_wr_valid_o  ( vreg_wr_valid_o  ),
                .vreg_wr_ready_i  ( vreg_wr_ready_i  ),
                .vreg_wr_o        ( vreg_wr_o        ),
                .xreg_valid_o     ( xreg_valid_o     ),
                .xreg_id_o        ( xreg_id_o        ),
                .xreg_addr_o      ( xreg_addr_o      ),
                .xreg_data_o      ( xreg_data_o      ),
                .instr_spec_i     ( instr_spec_i     ),
                .instr_killed_i   ( instr_killed_i   ),
                .pend_clear_o     ( pend_clear_o     ),
                .pend_clear_cnt_o ( pend_clear_cnt_o ),
                .instr_done_o     ( instr_done_o     )
        );

endmodule

`default_nettype wire

/* dv/elem_tb_clock.sv */
/* Testbench clock and reset
   20 ns clock, synchronous reset held for the first two rising edges */

`timescale 1ns/1ps
`default_nettype none

module elem_tb_clock (
        output logic clk_o,
        output logic reset_o
);

        initial begin
                clk_o   = 1'b0;
                reset_o = 1'b1;
                forever #10 clk_o = ~clk_o;
        end

        initial begin
                repeat (2) @(posedge clk_o);
                #2 reset_o = 1'b0;   // Released just after the second edge
        end

endmodule

`default_nettype wire

/* dv/elem_unit_tb.sv */
/* Element unit testbench
   Table of instructions driven through the DUT, checked against a packing reference model */

`timescale 1ns/1ps
`default_nettype none

module elem_unit_tb;

        typedef struct packed {
                elem_pkg::instr_id_t  id;
                elem_pkg::elem_op_t   op;
                elem_pkg::vsew_t      eew;
                elem_pkg::emul_t      emul;
                elem_pkg::vreg_addr_t base;
                elem_pkg::xreg_addr_t xaddr;
                logic [5:0]           beats;
                logic                 spec;   // Hold the id speculative for a while
                logic                 kill;
                logic                 bp;     // Random back-pressure on the vreg port
        } test_t;

        localparam int SPEC_HOLD = 10;

        logic                  clk, reset;
        logic                  in_valid, in_ready, in_mask;
        elem_pkg::elem_ctrl_t  in_ctrl;
        elem_pkg::word_t       in_elem;
        logic                  vreg_wr_valid, vreg_wr_ready;
        elem_pkg::vreg_wr_t    vreg_wr;
        logic                  xreg_valid;
        elem_pkg::instr_id_t   xreg_id;
        elem_pkg::xreg_addr_t  xreg_addr;
        elem_pkg::word_t       xreg_data;
        elem_pkg::id_flags_t   instr_spec, instr_killed;
        logic                  pend_clear, instr_done;
        elem_pkg::emul_t       pend_clear_cnt;

        test_t                 tests[$];
        string                 names[$];
        elem_pkg::vreg_wr_t    exp_wr[$];
        logic [39:0]           exp_x[$];   // {id, addr, data}
        elem_pkg::vreg_wr_t    mon_wr;
        logic [39:0]           mon_x;
        logic [31:0]           lfsr;
        int                    errors, test_errors, checks, done_seen;
        int                    cycles, cycle_limit, total_beats, spec_hold, ref_bytes;
        elem_pkg::word_t       ref_word;
        elem_pkg::byte_mask_t  ref_mask;
        string                 cur_name;
        test_t                 cur;

        elem_tb_clock clock_gen (.clk_o(clk), .reset_o(reset));

        elem_unit_top uut (
                .clk_i(clk), .reset_i(reset),
                .in_valid_i(in_valid), .in_ready_o(in_ready), .in_ctrl_i(in_ctrl),
                .in_elem_i(in_elem), .in_mask_i(in_mask),
                .vreg_wr_valid_o(vreg_wr_valid), .vreg_wr_ready_i(vreg_wr_ready),
                .vreg_wr_o(vreg_wr),
                .xreg_valid_o(xreg_valid), .xreg_id_o(xreg_id), .xreg_addr_o(xreg_addr),
                .xreg_data_o(xreg_data),
                .instr_spec_i(instr_spec), .instr_killed_i(instr_killed),
                .pend_clear_o(pend_clear), .pend_clear_cnt_o(pend_clear_cnt),
                .instr_done_o(instr_done)
        );

        // Taps 32, 22, 2, 1
        function automatic logic [31:0] lfsr_next(input logic [31:0] s);
                return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
        endfunction

        function automatic logic rand_bit();
                lfsr = lfsr_next(lfsr);
                return lfsr[0];
        endfunction

        function automatic logic [31:0] rand_word();
                logic [31:0] w;
                w = '0;
                for (int i = 0; i < 32; i++) begin
                        w = {w[30:0], rand_bit()};
                end
                return w;
        endfunction

        task automatic compare_value(input string what, input logic [63:0] expected,
                                     input logic [63:0] actual);
                checks++;
                if (expected !== actual) begin
                        $display("[FAIL] %s %s: expected %h, actual %h",
                                 cur_name, what, expected, actual);
                        errors++;
                        test_errors++;
                end
        endtask

        task automatic add_test(input string name, input elem_pkg::instr_id_t id,
                                input elem_pkg::elem_op_t op, input elem_pkg::vsew_t eew,
                                input elem_pkg::emul_t emul, input elem_pkg::vreg_addr_t base,
                                input logic [5:0] beats, input logic spec, input logic kill,
                                input logic bp);
                test_t t;
                t.id    = id;
                t.op    = op;
                t.eew   = eew;
                t.emul  = emul;
                t.base  = base;
                t.xaddr = {2'b01, id};
                t.beats = beats;
                t.spec  = spec;
                t.kill  = kill;
                t.bp    = bp;
                tests.push_back(t);
                names.push_back(name);
                total_beats += int'(beats);
        endtask

        task automatic push_write(input int ridx);
                elem_pkg::vreg_wr_t w;
                w.vaddr = cur.base | elem_pkg::vreg_addr_t'(ridx & ((1 << cur.emul) - 1));
                w.data  = ref_word;
                w.mask  = ref_mask;
                exp_wr.push_back(w);
                ref_word = '0;
                ref_mask = '0;
        endtask

        // Reference packing of one beat into the expected write and scalar queues
        task automatic model_beat(input logic [31:0] elem, input logic mask,
                                  input logic first, input logic last);
                int              nbytes;
                int              pos;
                int              ridx;
                logic            valid;
                elem_pkg::word_t e;
                case (cur.eew)
                        elem_pkg::VSEW_8:  nbytes = 1;
                        elem_pkg::VSEW_16: nbytes = 2;
                        default:           nbytes = 4;
                endcase
                e = elem;
                if (nbytes < 4) begin
                        e = elem & ((32'd1 << (8 * nbytes)) - 32'd1);
                end
                case (cur.op)
                        elem_pkg::ELEM_MOVE:     valid = 1'b1;
                        elem_pkg::ELEM_COMPRESS: valid = mask;
                        default:                 valid = first;
                endcase
                if (cur.op == elem_pkg::ELEM_XMV) begin
                        if (valid && !cur.kill) begin
                                exp_x.push_back({cur.id, cur.xaddr, e});
                        end
                end else if (valid) begin
                        pos  = ref_bytes % 4;
                        ridx = ref_bytes / 4;
                        ref_word = ref_word | (e << (8 * pos));
                        for (int k = 0; k < nbytes; k++) begin
                                ref_mask[pos + k] = 1'b1;
                        end
                        ref_bytes += nbytes;
                        if (ref_bytes % 4 == 0 || last) begin
                                push_write(ridx);
                        end
                end else if (last && ref_mask != '0) begin
                        push_write(ref_bytes / 4);
                end
        endtask

        task automatic next_cycle();
                @(posedge clk);
                #2;
                vreg_wr_ready = cur.bp ? rand_bit() : 1'b1;
                if (spec_hold > 0) begin
                        spec_hold--;
                        if (spec_hold == 0) instr_spec = '0;   // Speculation resolved
                end
        endtask

        task automatic run_test(input int idx);
                logic [31:0] data;
                logic        mask;
                logic        accepted;
                int          last;
                cur          = tests[idx];
                cur_name     = names[idx];
                test_errors  = 0;
                ref_bytes    = 0;
                ref_word     = '0;
                ref_mask     = '0;
                last         = int'(cur.beats) - 1;
                vreg_wr_ready = 1'b1;
                instr_spec   = cur.spec ? (8'd1 << cur.id) : 8'd0;
                instr_killed = cur.kill ? (8'd1 << cur.id) : 8'd0;
                spec_hold    = cur.spec ? SPEC_HOLD : 0;
                for (int b = 0; b <= last; b++) begin
                        data = rand_word();
                        mask = rand_bit();
                        in_ctrl.id          = cur.id;
                        in_ctrl.op          = cur.op;
                        in_ctrl.eew         = cur.eew;
                        in_ctrl.emul        = cur.emul;
                        in_ctrl.res_vaddr   = cur.base;
                        in_ctrl.xreg_addr   = cur.xaddr;
                        in_ctrl.first_cycle = (b == 0);
                        in_ctrl.last_cycle  = (b == last);
                        in_elem  = data;
                        in_mask  = mask;
                        in_valid = 1'b1;
                        model_beat(data, mask, b == 0, b == last);
                        accepted = 1'b0;
                        while (!accepted) begin
                                #16;
                                accepted = in_ready;   // Stable just before the edge
                                next_cycle();
                        end
                end
                in_valid = 1'b0;
                while (done_seen <= idx) begin
                        next_cycle();
                end
                compare_value("vreg writes missing", 64'd0, 64'(exp_wr.size()));
                compare_value("scalar results missing", 64'd0, 64'(exp_x.size()));
                $display("test %s: %0d beats, %0d errors", cur_name, cur.beats, test_errors);
        endtask

        // Outputs are sampled mid-cycle
        always @(negedge clk) begin
                if (!reset) begin
                        if (vreg_wr_valid && vreg_wr_ready) begin
                                if (exp_wr.size() == 0) begin
                                        $display("ERROR: %s wrote v%0d with no write expected",
                                                 cur_name, vreg_wr.vaddr);
                                        errors++;
                                end else begin
                                        mon_wr = exp_wr.pop_front();
                                        compare_value("vreg write", 64'(mon_wr), 64'(vreg_wr));
                                end
                        end
                        if (xreg_valid) begin
                                compare_value("xreg while speculative", 64'd0,
                                              64'(instr_spec[xreg_id]));
                                if (exp_x.size() == 0) begin
                                        $display("ERROR: %s issued a scalar result for id %0d",
                                                 cur_name, xreg_id);
                                        errors++;
                                end else begin
                                        mon_x = exp_x.pop_front();
                                        compare_value("xreg result", 64'(mon_x),
                                                      64'({xreg_id, xreg_addr, xreg_data}));
                                end
                        end
                        if (pend_clear && !instr_done) begin
                                $display("ERROR: %s pend_clear pulsed without instr_done",
                                         cur_name);
                                errors++;
                        end
                        if (instr_done) begin
                                compare_value("pend_clear", 64'(cur.op != elem_pkg::ELEM_XMV),
                                              64'(pend_clear));
                                if (cur.op != elem_pkg::ELEM_XMV) begin
                                        compare_value("pend_clear_cnt", 64'(cur.emul),
                                                      64'(pend_clear_cnt));
                                end
                                done_seen++;
                        end
                end
        end

        always @(posedge clk) begin
                cycles++;
                if (cycles >= cycle_limit) begin
                        $display("ERROR: run stopped after %0d cycles without finishing", cycles);
                        $display("RESULT: FAIL");
                        $finish;
                end
        end

        initial begin
                in_valid      = 1'b0;
                in_ctrl       = '0;
                in_elem       = '0;
                in_mask       = 1'b0;
                vreg_wr_ready = 1'b1;
                instr_spec    = '0;
                instr_killed  = '0;
                lfsr          = 32'h6391_a8a9;
                errors        = 0;
                checks        = 0;
                done_seen     = 0;
                cycles        = 0;
                spec_hold     = 0;
                total_beats   = 0;
                cur           = '0;
                cur_name      = "reset";

                add_test("move_e8", 3'd0, elem_pkg::ELEM_MOVE, elem_pkg::VSEW_8,
                         elem_pkg::EMUL_1, 5'd4, 6'd3, 1'b0, 1'b0, 1'b0);
                add_test("move_e16", 3'd1, elem_pkg::ELEM_MOVE, elem_pkg::VSEW_16,
                         elem_pkg::EMUL_1, 5'd5, 6'd1, 1'b0, 1'b0, 1'b0);
                add_test("move_e32", 3'd2, elem_pkg::ELEM_MOVE, elem_pkg::VSEW_32,
                         elem_pkg::EMUL_1, 5'd9, 6'd1, 1'b0, 1'b0, 1'b0);
                add_test("compress_e8", 3'd3, elem_pkg::ELEM_COMPRESS, elem_pkg::VSEW_8,
                         elem_pkg::EMUL_2, 5'd10, 6'd8, 1'b0, 1'b0, 1'b0);
                add_test("compress_e16", 3'd4, elem_pkg::ELEM_COMPRESS, elem_pkg::VSEW_16,
                         elem_pkg::EMUL_2, 5'd2, 6'd4, 1'b0, 1'b0, 1'b0);
                add_test("group_m2", 3'd5, elem_pkg::ELEM_MOVE, elem_pkg::VSEW_32,
                         elem_pkg::EMUL_2, 5'd6, 6'd2, 1'b0, 1'b0, 1'b0);
                add_test("group_m4", 3'd6, elem_pkg::ELEM_MOVE, elem_pkg::VSEW_16,
                         elem_pkg::EMUL_4, 5'd8, 6'd8, 1'b0, 1'b0, 1'b0);
                add_test("group_m8", 3'd7, elem_pkg::ELEM_MOVE, elem_pkg::VSEW_8,
                         elem_pkg::EMUL_8, 5'd16, 6'd32, 1'b0, 1'b0, 1'b0);
                add_test("xmv", 3'd0, elem_pkg::ELEM_XMV, elem_pkg::VSEW_16,
                         elem_pkg::EMUL_1, 5'd0, 6'd3, 1'b0, 1'b0, 1'b0);
                add_test("xmv_spec", 3'd1, elem_pkg::ELEM_XMV, elem_pkg::VSEW_32,
                         elem_pkg::EMUL_2, 5'd0, 6'd3, 1'b1, 1'b0, 1'b0);
                add_test("xmv_kill", 3'd2, elem_pkg::ELEM_XMV, elem_pkg::VSEW_8,
                         elem_pkg::EMUL_1, 5'd0, 6'd2, 1'b0, 1'b1, 1'b0);
                add_test("backpressure", 3'd3, elem_pkg::ELEM_MOVE, elem_pkg::VSEW_8,
                         elem_pkg::EMUL_4, 5'd12, 6'd16, 1'b0, 1'b0, 1'b1);
                cycle_limit = 2 * total_beats + 200;

                @(negedge reset);
                @(posedge clk);
                #2;
                for (int t = 0; t < tests.size(); t++) begin
                        run_test(t);
                end

                $display("tests: %0d, checks: %0d, errors: %0d", tests.size(), checks, errors);
                if (errors == 0) begin
                        $display("RESULT: PASS");
                end else begin
                        $display("RESULT: FAIL");
                end
                $finish;
        end

endmodule

`default_nettype wire

/* elem_unit.f */
logic/elem_pkg.sv
logic/elem_op_stage.sv
logic/elem_vd_packer.sv
logic/elem_writeback.sv
logic/elem_unit_top.sv
dv/elem_tb_clock.sv
dv/elem_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the element unit testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f elem_unit.f --top-module elem_unit_tb \
        -Mdir obj_dir -o elem_unit_sim || { echo "build failed"; exit 1; }

sim_out="$(./obj_dir/elem_unit_sim)"
echo "$sim_out"
echo "$sim_out" | grep -qx "RESULT: PASS" && exit 0 || exit 1
